// File: verilog/scene_pkg.sv
//////////////////////////////////////////////////////////////////////
// Object scene package: screen geometry, object count, coordinate
// and color types, and the per-object configuration record
//////////////////////////////////////////////////////////////////////

package scene_pkg;

    // Object count and index width
    localparam int OBJECT_AMOUNT       = 4;
    localparam int OBJECT_AMOUNT_WIDTH = 2;

    // Visible area in pixels
    localparam int H_ACTIVE = 32;
    localparam int V_ACTIVE = 24;

    // Full frame including blanking, 1040 clocks per frame
    localparam int H_TOTAL = 40;
    localparam int V_TOTAL = 26;

    // Shown where no object draws
    localparam logic [7:0] BACKGROUND_COLOR = 8'h00;

    // Pixel coordinates, wide enough for the totals
    typedef logic [5:0] coord_x_t;
    typedef logic [4:0] coord_y_t;

    // One bit per object, or one object number
    typedef logic [OBJECT_AMOUNT_WIDTH-1:0] object_index_t;
    typedef logic [OBJECT_AMOUNT-1:0]       object_mask_t;

    typedef logic [7:0] color_t;

    // Settings of one box, 28 bits
    // Width or height of 0 draws nothing
    typedef struct packed {
        coord_x_t   pos_x;
        coord_y_t   pos_y;
        logic [3:0] width;
        logic [3:0] height;
        color_t     color;
        logic       deactivated;
    } object_cfg_t;

endpackage

// File: verilog/raster_scan.sv
//////////////////////////////////////////////////////////////////////
// Raster scanner: one pixel per clock over the full frame, with the
// visible-area flag and the first-pixel-of-frame strobe
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module raster_scan (
    input  logic                clk,
    input  logic                resetN,
    output scene_pkg::coord_x_t pixel_x,
    output scene_pkg::coord_y_t pixel_y,
    output logic                active,
    output logic                start_of_frame
);

    // Last pixel of a line and last line of a frame
    logic line_end;
    logic frame_end;

    assign line_end  = (pixel_x == scene_pkg::coord_x_t'(scene_pkg::H_TOTAL - 1));
    assign frame_end = (pixel_y == scene_pkg::coord_y_t'(scene_pkg::V_TOTAL - 1));

    // Horizontal counter, wraps every line
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            pixel_x <= '0;
        end else if (line_end) begin
            pixel_x <= '0;
        end else begin
            pixel_x <= pixel_x + 1'b1;
        end
    end

    // Vertical counter, steps once per line
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            pixel_y <= '0;
        end else if (line_end) begin
            if (frame_end) begin
                pixel_y <= '0;
            end else begin
                pixel_y <= pixel_y + 1'b1;
            end
        end
    end

    // Visible region only, blanking lies past the active counts
    assign active = (pixel_x < scene_pkg::coord_x_t'(scene_pkg::H_ACTIVE)) &&
                    (pixel_y < scene_pkg::coord_y_t'(scene_pkg::V_ACTIVE));

    // High on pixel (0, 0) only
    assign start_of_frame = (pixel_x == '0) && (pixel_y == '0);

endmodule

// File: verilog/box_object.sv
//////////////////////////////////////////////////////////////////////
// Box object: double-buffered settings of one solid rectangle and
// its draw request at the current pixel
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module box_object (
    input  logic                   clk,
    input  logic                   resetN,
    input  logic                   cfg_wr,
    input  scene_pkg::object_cfg_t cfg_data,
    input  logic                   start_of_frame,
    input  scene_pkg::coord_x_t    pixel_x,
    input  scene_pkg::coord_y_t    pixel_y,
    input  logic                   active,
    output logic                   draw_request,
    output logic                   object_deactivated,
    output scene_pkg::color_t      color
);

    // Settings written by software, not yet shown
    scene_pkg::object_cfg_t pending_cfg;
    // Settings in use for the current frame
    scene_pkg::object_cfg_t live_cfg;

    // One extra bit so that corner plus size cannot wrap
    logic [6:0] x_end;
    logic [5:0] y_end;
    logic       inside_x;
    logic       inside_y;

    // Writes land in the pending copy only
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            pending_cfg <= '0;
        end else if (cfg_wr) begin
            pending_cfg <= cfg_data;
        end
    end

    // Promote at the end of the first pixel of a frame
    // so the whole following frame sees one setting
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            live_cfg <= '0;
        end else if (start_of_frame) begin
            live_cfg <= pending_cfg;
        end
    end

    assign x_end = {1'b0, live_cfg.pos_x} + {3'b000, live_cfg.width};
    assign y_end = {1'b0, live_cfg.pos_y} + {2'b00, live_cfg.height};

    // Left and top edges inclusive, right and bottom exclusive
    assign inside_x = (pixel_x >= live_cfg.pos_x) && ({1'b0, pixel_x} < x_end);
    assign inside_y = (pixel_y >= live_cfg.pos_y) && ({1'b0, pixel_y} < y_end);

    // Never request in blanking
    assign draw_request = active && inside_x && inside_y;

    assign object_deactivated = live_cfg.deactivated;
    assign color              = live_cfg.color;

endmodule

// File: verilog/check_overlap.sv
//////////////////////////////////////////////////////////////////////
// Overlap check: lowest and highest active requester at each pixel,
// registered pulse when two different objects want the same pixel
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module check_overlap (
    input  logic                     clk,
    input  logic                     resetN,
    input  scene_pkg::object_mask_t  draw_request,
    input  scene_pkg::object_mask_t  object_deactivated,
    output logic                     overlap,
    output logic                     any_DR,
    output scene_pkg::object_index_t first_object_index
);

    scene_pkg::object_index_t last_object_index;

    // First requester, scanned downward so the lowest index stays
    always_comb begin
        first_object_index = '0;
        any_DR             = 1'b0;
        for (int j = scene_pkg::OBJECT_AMOUNT - 1; j >= 0; j--) begin
            // Deactivated objects are ignored
            if (draw_request[j] && !object_deactivated[j]) begin
                first_object_index = scene_pkg::object_index_t'(j);
                any_DR             = 1'b1;
            end
        end
    end

    // Last requester, scanned upward so the highest index stays
    always_comb begin
        last_object_index = '0;
        for (int i = 0; i < scene_pkg::OBJECT_AMOUNT; i++) begin
            if (draw_request[i] && !object_deactivated[i]) begin
                last_object_index = scene_pkg::object_index_t'(i);
            end
        end
    end

    // No requester or a single one gives equal indices
    // Two or more give different ones
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            overlap <= 1'b0;
        end else begin
            overlap <= (first_object_index != last_object_index);
        end
    end

endmodule

// File: verilog/pixel_select.sv
//////////////////////////////////////////////////////////////////////
// Pixel selector: registered color of the lowest active object or
// the background, with the matching delayed frame flags
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pixel_select (
    input  logic                     clk,
    input  logic                     resetN,
    input  logic                     active,
    input  logic                     start_of_frame,
    input  logic                     any_DR,
    input  scene_pkg::object_index_t first_object_index,
    input  scene_pkg::color_t        object_color [scene_pkg::OBJECT_AMOUNT],
    output scene_pkg::color_t        rgb,
    output logic                     pixel_valid,
    output logic                     frame_start
);

    // Winner color or background, before the register
    scene_pkg::color_t next_rgb;

    // Lowest active index already chosen by the overlap check
    assign next_rgb = any_DR ? object_color[first_object_index]
                             : scene_pkg::BACKGROUND_COLOR;

    // Color lags the pixel by one clock
    always_ff @(posedge clk) begin
        rgb <= next_rgb;
    end

    // Flags delayed to stay aligned with rgb
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            pixel_valid <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            pixel_valid <= active;
            frame_start <= start_of_frame;
        end
    end

endmodule

// File: verilog/frame_collision.sv
//////////////////////////////////////////////////////////////////////
// Frame collision unit: ORs the overlapping objects over one frame
// and reports the mask on the first cycle of the next frame
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module frame_collision (
    input  logic                    clk,
    input  logic                    resetN,
    input  scene_pkg::object_mask_t draw_request,
    input  scene_pkg::object_mask_t object_deactivated,
    input  logic                    overlap,
    input  logic                    frame_start,
    output logic                    collision_valid,
    output scene_pkg::object_mask_t collision_mask
);

    // Active requesters, delayed one cycle to meet overlap
    scene_pkg::object_mask_t active_mask_q;
    // Objects seen overlapping so far in this frame
    scene_pkg::object_mask_t accum_mask;
    // Contribution of the pixel that overlap refers to
    scene_pkg::object_mask_t hit_mask;

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            active_mask_q <= '0;
        end else begin
            active_mask_q <= draw_request & ~object_deactivated;
        end
    end

    assign hit_mask = overlap ? active_mask_q : '0;

    // On frame start the old sum is reported and a new one begins
    // Overlap in that cycle already belongs to the new frame
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            accum_mask <= '0;
        end else if (frame_start) begin
            accum_mask <= hit_mask;
        end else begin
            accum_mask <= accum_mask | hit_mask;
        end
    end

    // Report holds the previous frame up to its last pixel
    assign collision_valid = frame_start;
    assign collision_mask  = frame_start ? accum_mask : '0;

endmodule

// File: verilog/object_scene.sv
//////////////////////////////////////////////////////////////////////
// Object scene top: raster scanner, four boxes, overlap check,
// pixel selector and frame collision unit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module object_scene (
    input  logic                     clk,
    input  logic                     resetN,
    input  logic                     cfg_wr,
    input  scene_pkg::object_index_t cfg_index,
    input  scene_pkg::object_cfg_t   cfg_data,
    output logic                     frame_start,
    output logic                     pixel_valid,
    output scene_pkg::color_t        rgb,
    output logic                     overlap,
    output logic                     collision_valid,
    output scene_pkg::object_mask_t  collision_mask
);

    // Raster
    scene_pkg::coord_x_t pixel_x;
    scene_pkg::coord_y_t pixel_y;
    logic                active;
    logic                start_of_frame;

    // Per-object signals
    scene_pkg::object_mask_t cfg_sel;
    scene_pkg::object_mask_t draw_request;
    scene_pkg::object_mask_t object_deactivated;
    scene_pkg::color_t       object_color [scene_pkg::OBJECT_AMOUNT];

    // Winner of the current pixel
    logic                     any_DR;
    scene_pkg::object_index_t first_object_index;

    raster_scan u_raster_scan (
        .clk            (clk),
        .resetN         (resetN),
        .pixel_x        (pixel_x),
        .pixel_y        (pixel_y),
        .active         (active),
        .start_of_frame (start_of_frame)
    );

    // One box per object, each sees only its own write strobe
    for (genvar i = 0; i < scene_pkg::OBJECT_AMOUNT; i++) begin : g_box
        assign cfg_sel[i] = cfg_wr && (cfg_index == scene_pkg::object_index_t'(i));

        box_object u_box_object (
            .clk                (clk),
            .resetN             (resetN),
            .cfg_wr             (cfg_sel[i]),
            .cfg_data           (cfg_data),
            .start_of_frame     (start_of_frame),
            .pixel_x            (pixel_x),
            .pixel_y            (pixel_y),
            .active             (active),
            .draw_request       (draw_request[i]),
            .object_deactivated (object_deactivated[i]),
            .color              (object_color[i])
        );
    end

    check_overlap u_check_overlap (
        .clk                (clk),
        .resetN             (resetN),
        .draw_request       (draw_request),
        .object_deactivated (object_deactivated),
        .overlap            (overlap),
        .any_DR             (any_DR),
        .first_object_index (first_object_index)
    );

    pixel_select u_pixel_select (
        .clk                (clk),
        .resetN             (resetN),
        .active             (active),
        .start_of_frame     (start_of_frame),
        .any_DR             (any_DR),
        .first_object_index (first_object_index),
        .object_color       (object_color),
        .rgb                (rgb),
        .pixel_valid        (pixel_valid),
        .frame_start        (frame_start)
    );

    // Mask is rebuilt here from the raw requests
    frame_collision u_frame_collision (
        .clk                (clk),
        .resetN             (resetN),
        .draw_request       (draw_request),
        .object_deactivated (object_deactivated),
        .overlap            (overlap),
        .frame_start        (frame_start),
        .collision_valid    (collision_valid),
        .collision_mask     (collision_mask)
    );

endmodule

// File: tests/object_scene_chk.sv
//////////////////////////////////////////////////////////////////////
// Scene checker bound to the top level: collision report timing,
// frame period and overlap confined to visible pixels
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module object_scene_chk (
    input logic clk,
    input logic resetN,
    input logic frame_start,
    input logic pixel_valid,
    input logic overlap,
    input logic collision_valid
);

    localparam int FRAME_CYCLES = scene_pkg::H_TOTAL * scene_pkg::V_TOTAL;

    // Cycles since the last frame start
    int   gap;
    logic seen_frame;
    int   fail_count = 0;

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            gap        <= 0;
            seen_frame <= 1'b0;
        end else if (frame_start) begin
            gap        <= 0;
            seen_frame <= 1'b1;
        end else begin
            gap <= gap + 1;
        end
    end

    // Report only on the first cycle of a frame
    assert property (@(posedge clk) disable iff (!resetN) collision_valid |-> frame_start)
        else begin
            $error("collision_valid high without frame_start");
            fail_count++;
        end

    // Frame starts exactly one frame apart
    assert property (@(posedge clk) disable iff (!resetN)
        (frame_start && seen_frame) |-> (gap == FRAME_CYCLES - 1))
        else begin
            $error("frame_start came early, gap %0d", gap);
            fail_count++;
        end

    // A missing frame start lets the gap run past one frame
    assert property (@(posedge clk) disable iff (!resetN) gap < FRAME_CYCLES)
        else begin
            $error("frame_start missing for a whole frame");
            fail_count++;
        end

    // Objects only draw inside the visible area
    assert property (@(posedge clk) disable iff (!resetN) overlap |-> pixel_valid)
        else begin
            $error("overlap high outside the visible area");
            fail_count++;
        end

endmodule

// File: tests/object_scene_mon.sv
//////////////////////////////////////////////////////////////////////
// Scene monitor: reference model of raster, boxes, colors, overlap
// and frame collision masks, compared against the DUT every cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module object_scene_mon (
    input  logic                     clk,
    input  logic                     resetN,
    input  logic                     cfg_wr,
    input  scene_pkg::object_index_t cfg_index,
    input  scene_pkg::object_cfg_t   cfg_data,
    input  logic                     frame_start,
    input  logic                     pixel_valid,
    input  scene_pkg::color_t        rgb,
    input  logic                     overlap,
    input  logic                     collision_valid,
    input  scene_pkg::object_mask_t  collision_mask,
    output int                       error_count,
    output int                       report_count
);

    // Model copies of every box
    scene_pkg::object_cfg_t  pending_q [scene_pkg::OBJECT_AMOUNT];
    scene_pkg::object_cfg_t  live_q    [scene_pkg::OBJECT_AMOUNT];
    int                      scan_x;
    int                      scan_y;
    // OR of overlapping masks since the current frame began
    scene_pkg::object_mask_t frame_accum;
    // Set once a reset edge has been seen, so idle values are defined
    logic                    reset_seen = 1'b0;
    // Expected outputs one cycle after the modeled pixel
    logic                    have_exp = 1'b0;
    scene_pkg::color_t       exp_rgb;
    logic                    exp_overlap;
    logic                    exp_valid;
    logic                    exp_frame_start;
    scene_pkg::object_mask_t exp_coll_mask;

    initial begin
        error_count  = 0;
        report_count = 0;
    end

    // Corner inclusive, corner plus size exclusive
    function automatic logic box_covers(input scene_pkg::object_cfg_t cfg,
                                        input int x, input int y);
        return (x >= int'(cfg.pos_x)) && (x < int'(cfg.pos_x) + int'(cfg.width)) &&
               (y >= int'(cfg.pos_y)) && (y < int'(cfg.pos_y) + int'(cfg.height));
    endfunction

    task automatic compare_value(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
            error_count++;
        end
    endtask

    // Model step on the same edge that registers the DUT outputs
    always @(posedge clk) begin : model_step
        scene_pkg::object_mask_t req_mask;
        logic                    visible;
        int                      winner;
        int                      hits;
        if (!resetN) begin
            scan_x      = 0;
            scan_y      = 0;
            frame_accum = '0;
            have_exp    = 1'b0;
            reset_seen  = 1'b1;
            for (int i = 0; i < scene_pkg::OBJECT_AMOUNT; i++) begin
                pending_q[i] = '0;
                live_q[i]    = '0;
            end
        end else begin
            visible  = (scan_x < scene_pkg::H_ACTIVE) && (scan_y < scene_pkg::V_ACTIVE);
            req_mask = '0;
            winner   = -1;
            hits     = 0;
            for (int i = 0; i < scene_pkg::OBJECT_AMOUNT; i++) begin
                if (visible && !live_q[i].deactivated &&
                    box_covers(live_q[i], scan_x, scan_y)) begin
                    req_mask[i] = 1'b1;
                    hits++;
                    // Lowest index keeps the pixel
                    if (winner < 0) begin
                        winner = i;
                    end
                end
            end
            exp_rgb         = (winner < 0) ? scene_pkg::BACKGROUND_COLOR : live_q[winner].color;
            exp_overlap     = (hits >= 2);
            exp_valid       = visible;
            exp_frame_start = (scan_x == 0) && (scan_y == 0);
            // Previous frame is reported on the first pixel of the new one
            exp_coll_mask   = exp_frame_start ? frame_accum : '0;
            if (exp_frame_start) begin
                frame_accum = '0;
            end
            if (exp_overlap) begin
                frame_accum = frame_accum | req_mask;
            end
            // Promotion sees pending as it stood before this edge
            if (exp_frame_start) begin
                live_q = pending_q;
            end
            if (cfg_wr) begin
                pending_q[cfg_index] = cfg_data;
            end
            scan_x = (scan_x == scene_pkg::H_TOTAL - 1) ? 0 : scan_x + 1;
            if (scan_x == 0) begin
                scan_y = (scan_y == scene_pkg::V_TOTAL - 1) ? 0 : scan_y + 1;
            end
            have_exp = 1'b1;
        end
    end

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (have_exp) begin
            compare_value("rgb", rgb, exp_rgb);
            compare_value("overlap", overlap, exp_overlap);
            compare_value("pixel_valid", pixel_valid, exp_valid);
            compare_value("frame_start", frame_start, exp_frame_start);
            compare_value("collision_valid", collision_valid, exp_frame_start);
            compare_value("collision_mask", collision_mask, exp_coll_mask);
            if (exp_frame_start) begin
                report_count++;
            end
        end else if (reset_seen) begin
            // Idle values before the first pixel
            compare_value("overlap", overlap, 8'h00);
            compare_value("pixel_valid", pixel_valid, 8'h00);
            compare_value("frame_start", frame_start, 8'h00);
            compare_value("collision_valid", collision_valid, 8'h00);
            compare_value("collision_mask", collision_mask, 8'h00);
        end
    end

endmodule

// File: tests/object_scene_tb.sv
//////////////////////////////////////////////////////////////////////
// Scene testbench: clock, reset and random box writes over a run of
// frames, with monitor, bound checker and the final report
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module object_scene_tb;

    localparam int FRAME_CYCLES   = scene_pkg::H_TOTAL * scene_pkg::V_TOTAL;
    localparam int RUN_FRAMES     = 12;
    // Run length plus two frames of slack
    localparam int TIMEOUT_CYCLES = (RUN_FRAMES + 2) * FRAME_CYCLES;

    logic                     clk;
    logic                     resetN;
    logic                     cfg_wr;
    scene_pkg::object_index_t cfg_index;
    scene_pkg::object_cfg_t   cfg_data;
    logic                     frame_start;
    logic                     pixel_valid;
    scene_pkg::color_t        rgb;
    logic                     overlap;
    logic                     collision_valid;
    scene_pkg::object_mask_t  collision_mask;
    int                       error_count;
    int                       report_count;
    int                       cycle_count;
    logic [31:0]              lfsr_state;

    object_scene u_object_scene (.*);

    object_scene_mon u_object_scene_mon (.*);

    bind object_scene object_scene_chk u_object_scene_chk (.*);

    // Galois LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic int random_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = (value << 1) | int'(lfsr_state[0]);
        end
        return value;
    endfunction

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_frame_start();
        next_cycle();
        while (!frame_start) begin
            next_cycle();
        end
    endtask

    // Boxes near the screen center, so they often overlap
    task automatic write_random_box();
        scene_pkg::object_cfg_t cfg;
        cfg.pos_x       = scene_pkg::coord_x_t'(8 + random_bits(4));
        cfg.pos_y       = scene_pkg::coord_y_t'(6 + random_bits(3));
        cfg.width       = 4'(random_bits(4));
        cfg.height      = 4'(random_bits(4));
        cfg.color       = scene_pkg::color_t'(random_bits(8)) | 8'h01;
        cfg.deactivated = (random_bits(2) == 0);
        cfg_index       = scene_pkg::object_index_t'(random_bits(2));
        cfg_data        = cfg;
        cfg_wr          = 1'b1;
        next_cycle();
        cfg_wr          = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int writes;
        int gap;
        int short_run;
        int assert_fails;
        lfsr_state = 32'h89cbdc43;
        resetN     = 1'b0;
        cfg_wr     = 1'b0;
        cfg_index  = '0;
        cfg_data   = '0;
        repeat (2) @(posedge clk);
        #1;
        resetN = 1'b1;
        // A few writes at random pixel times in every frame
        for (int f = 0; f < RUN_FRAMES; f++) begin
            wait_frame_start();
            writes = 1 + random_bits(2);
            for (int w = 0; w < writes; w++) begin
                gap = random_bits(7);
                repeat (gap) next_cycle();
                write_random_box();
            end
        end
        // The last frame still reports its collisions
        wait_frame_start();
        next_cycle();
        short_run = 0;
        if (report_count < RUN_FRAMES) begin
            $display("too few collision reports seen: %0d", report_count);
            short_run = 1;
        end
        assert_fails = u_object_scene.u_object_scene_chk.fail_count;
        $display("errors: %0d compare, %0d assertion, %0d report count",
                 error_count, assert_fails, short_run);
        if (error_count + assert_fails + short_run == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: object_scene.f
verilog/scene_pkg.sv
verilog/raster_scan.sv
verilog/box_object.sv
verilog/check_overlap.sv
verilog/pixel_select.sv
verilog/frame_collision.sv
verilog/object_scene.sv
tests/object_scene_chk.sv
tests/object_scene_mon.sv
tests/object_scene_tb.sv
